/* include/spi_rx_macros.svh */
/*
 * serial receiver constants
 * word and frame widths, queue depth, credits, lost counter width
 */
`ifndef SPI_RX_MACROS_SVH
`define SPI_RX_MACROS_SVH

// data bits per received word
`define WORD_BITS 16

// frame counter width
`define FRAME_BITS 12

// entries per lane queue
`define LANE_FIFO_DEPTH 4

// consumer buffer size, credits after reset
`define OUT_CREDITS 4

// saturating lost-word counter width
`define LOST_BITS 8

`endif

/* hdl/spi_rx_pkg.sv */
/*
 * serial receiver types
 * tagged word and per-lane status structs
 */
`default_nettype none

`include "spi_rx_macros.svh"

package spi_rx_pkg;

    // lane identifier carried in every word
    typedef logic [3:0] lane_id_t;

    //////////////////////////////
    // 32-bit output word
    //////////////////////////////
    typedef struct packed {
        lane_id_t                lane_id;
        logic [`FRAME_BITS-1:0]  frame;
        logic [`WORD_BITS-1:0]   data;
    } rx_word_t;

    // lane status with lost words and current frame
    typedef struct packed {
        logic [`LOST_BITS-1:0]   lost;
        logic [`FRAME_BITS-1:0]  frame;
    } lane_status_t;

endpackage

`default_nettype wire

/* hdl/stream_fifo.sv */
/*
 * synchronous FIFO for any payload type
 * head visible without latency, push when full is ignored
 */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire           SCLK,
    input  wire           RST,
    input  wire           push,
    input  wire payload_t push_data,
    output logic          full,
    input  wire           pop,
    output payload_t      pop_data,
    output logic          not_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && not_empty;

    // storage
    always_ff @(posedge SCLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // pointers and occupancy
    always_ff @(posedge SCLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    assign pop_data  = mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/spi_rx_lane.sv */
/*
 * serial lane receiver
 * packs sdi bits into tagged words and queues them, counts lost words
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_macros.svh"

module spi_rx_lane #(
    parameter spi_rx_pkg::lane_id_t LANE_ID = 4'd1
) (
    input  wire                      SCLK,
    input  wire                      RST,
    input  wire                      enable,
    input  wire                      sdi,
    input  wire                      sen,
    input  wire                      pop,
    output spi_rx_pkg::rx_word_t     head,
    output logic                     not_empty,
    output spi_rx_pkg::lane_status_t status
);

    import spi_rx_pkg::*;

    localparam int WB    = `WORD_BITS;
    localparam int BIT_W = $clog2(WB);

    logic                   sen_dly;
    logic                   sen_fall;
    logic                   shifting;
    logic                   full_word;
    logic                   partial_word;
    logic [BIT_W-1:0]       bit_cnt;
    logic [WB-1:0]          shift_reg;
    logic [`FRAME_BITS-1:0] frame_cnt;
    logic [`LOST_BITS-1:0]  lost_cnt;
    logic                   stage_valid;
    rx_word_t               stage_word;
    logic                   fifo_full;

    assign sen_fall     = sen_dly && !sen;
    assign shifting     = enable && sen;
    assign full_word    = shifting && (bit_cnt == BIT_W'(WB - 1));
    assign partial_word = enable && sen_fall && (bit_cnt != '0);

    //////////////////////////////
    // bit packing
    //////////////////////////////
    always_ff @(posedge SCLK) begin
        if (RST) begin
            sen_dly   <= 1'b0;
            bit_cnt   <= '0;
            shift_reg <= '0;
        end else begin
            sen_dly <= sen;
            // a completed word or a frame end restarts the packer
            if (full_word || sen_fall) begin
                bit_cnt   <= '0;
                shift_reg <= '0;
            end else if (shifting) begin
                bit_cnt   <= bit_cnt + 1'b1;
                shift_reg <= {shift_reg[WB-2:0], sdi};
            end
        end
    end

    // frame number steps on sen fall
    always_ff @(posedge SCLK) begin
        if (RST)
            frame_cnt <= '0;
        else if (enable && sen_fall)
            frame_cnt <= frame_cnt + 1'b1;
    end

    //////////////////////////////
    // one-cycle word staging
    //////////////////////////////
    always_ff @(posedge SCLK) begin
        if (RST)
            stage_valid <= 1'b0;
        else
            stage_valid <= full_word || partial_word;
    end

    // frame taken before the increment at sen fall
    always_ff @(posedge SCLK) begin
        stage_word.lane_id <= LANE_ID;
        stage_word.frame   <= frame_cnt;
        stage_word.data    <= full_word ? {shift_reg[WB-2:0], sdi} : shift_reg;
    end

    // saturating count of dropped words
    always_ff @(posedge SCLK) begin
        if (RST)
            lost_cnt <= '0;
        else if (stage_valid && fifo_full && (lost_cnt != '1))
            lost_cnt <= lost_cnt + 1'b1;
    end

    stream_fifo #(
        .payload_t (rx_word_t),
        .DEPTH     (`LANE_FIFO_DEPTH)
    ) queue_i (
        .SCLK      (SCLK),
        .RST       (RST),
        .push      (stage_valid),
        .push_data (stage_word),
        .full      (fifo_full),
        .pop       (pop),
        .pop_data  (head),
        .not_empty (not_empty)
    );

    assign status.lost  = lost_cnt;
    assign status.frame = frame_cnt;

endmodule

`default_nettype wire

/* hdl/lane_merge.sv */
/*
 * two-lane round-robin merge
 * pops a lane queue only while the consumer has buffer credit
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_macros.svh"

module lane_merge (
    input  wire                  SCLK,
    input  wire                  RST,
    input  wire spi_rx_pkg::rx_word_t head_a,
    input  wire                  not_empty_a,
    output logic                 pop_a,
    input  wire spi_rx_pkg::rx_word_t head_b,
    input  wire                  not_empty_b,
    output logic                 pop_b,
    input  wire                  credit_return,
    output spi_rx_pkg::rx_word_t out_word,
    output logic                 out_valid
);

    import spi_rx_pkg::*;

    localparam int CRED_W = $clog2(`OUT_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              prio_b;
    logic              can_send;
    logic              grant_a;
    logic              grant_b;

    //////////////////////////////
    // arbitration
    //////////////////////////////
    // one credit is already spoken for while out_valid is high
    assign can_send = (credits > CRED_W'(out_valid));

    assign grant_a = can_send && not_empty_a && (!not_empty_b || !prio_b);
    assign grant_b = can_send && not_empty_b && (!not_empty_a || prio_b);

    assign pop_a = grant_a;
    assign pop_b = grant_b;

    // credits spent by out_valid and refilled by the consumer
    always_ff @(posedge SCLK) begin
        if (RST)
            credits <= CRED_W'(`OUT_CREDITS);
        else
            credits <= credits + CRED_W'(credit_return) - CRED_W'(out_valid);
    end

    // served lane loses priority
    always_ff @(posedge SCLK) begin
        if (RST)
            prio_b <= 1'b0;
        else if (grant_a)
            prio_b <= 1'b1;
        else if (grant_b)
            prio_b <= 1'b0;
    end

    //////////////////////////////
    // output register
    //////////////////////////////
    always_ff @(posedge SCLK) begin
        if (RST)
            out_valid <= 1'b0;
        else
            out_valid <= grant_a || grant_b;
    end

    always_ff @(posedge SCLK) begin
        if (grant_a)
            out_word <= head_a;
        else if (grant_b)
            out_word <= head_b;
    end

endmodule

`default_nettype wire

/* hdl/spi_rx_subsystem.sv */
/*
 * two-lane serial receiver
 * lanes A and B merged into one credit-controlled stream
 */
`timescale 1ns/1ps
`default_nettype none

module spi_rx_subsystem (
    input  wire                      SCLK,
    input  wire                      RST,
    input  wire                      enable,
    input  wire                      sdi_a,
    input  wire                      sen_a,
    input  wire                      sdi_b,
    input  wire                      sen_b,
    input  wire                      credit_return,
    output spi_rx_pkg::rx_word_t     out_word,
    output logic                     out_valid,
    output spi_rx_pkg::lane_status_t status_a,
    output spi_rx_pkg::lane_status_t status_b
);

    import spi_rx_pkg::*;

    // lane queue heads toward the merge
    rx_word_t head_a;
    rx_word_t head_b;
    logic     not_empty_a;
    logic     not_empty_b;
    logic     pop_a;
    logic     pop_b;

    //////////////////////////////
    // lanes
    //////////////////////////////
    spi_rx_lane #(
        .LANE_ID   (lane_id_t'(1))
    ) lane_a_i (
        .SCLK      (SCLK),
        .RST       (RST),
        .enable    (enable),
        .sdi       (sdi_a),
        .sen       (sen_a),
        .pop       (pop_a),
        .head      (head_a),
        .not_empty (not_empty_a),
        .status    (status_a)
    );

    spi_rx_lane #(
        .LANE_ID   (lane_id_t'(2))
    ) lane_b_i (
        .SCLK      (SCLK),
        .RST       (RST),
        .enable    (enable),
        .sdi       (sdi_b),
        .sen       (sen_b),
        .pop       (pop_b),
        .head      (head_b),
        .not_empty (not_empty_b),
        .status    (status_b)
    );

    // merge stage
    lane_merge merge_i (
        .SCLK          (SCLK),
        .RST           (RST),
        .head_a        (head_a),
        .not_empty_a   (not_empty_a),
        .pop_a         (pop_a),
        .head_b        (head_b),
        .not_empty_b   (not_empty_b),
        .pop_b         (pop_b),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

/* tb/spi_rx_props.sv */
/*
 * credit and queue properties
 * bound into the merge stage and every lane queue
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_macros.svh"

module spi_rx_props #(
    parameter int CRED_W = $clog2(`OUT_CREDITS + 1)
) (
    input wire              SCLK,
    input wire              RST,
    input wire              out_valid,
    input wire [CRED_W-1:0] credits,
    input wire              pop,
    input wire              not_empty
);

    // no word leaves without a credit
    a_valid_needs_credit: assert property (
        @(posedge SCLK) disable iff (RST) out_valid |-> (credits != '0)
    ) else $error("out_valid high with zero credits");

    a_credit_limit: assert property (
        @(posedge SCLK) disable iff (RST) credits <= CRED_W'(`OUT_CREDITS)
    ) else $error("credit count above limit");

    // queue never popped while empty
    a_pop_not_empty: assert property (
        @(posedge SCLK) disable iff (RST) pop |-> not_empty
    ) else $error("pop on empty queue");

    a_quiet_after_reset: assert property (
        @(posedge SCLK) RST |=> !out_valid
    ) else $error("out_valid high after reset");

endmodule

bind lane_merge spi_rx_props merge_props_i (
    .SCLK      (SCLK),
    .RST       (RST),
    .out_valid (out_valid),
    .credits   (credits),
    .pop       (pop_a),
    .not_empty (not_empty_a)
);

bind stream_fifo spi_rx_props fifo_props_i (
    .SCLK      (SCLK),
    .RST       (RST),
    .out_valid (1'b0),
    .credits   ('0),
    .pop       (pop),
    .not_empty (not_empty)
);

`default_nettype wire

/* tb/spi_rx_tb.sv */
/*
 * testbench for the two-lane serial receiver
 * random frames per lane, credit consumer, per-lane expected word queues
 */
`timescale 1ns/1ps
`default_nettype none

`include "spi_rx_macros.svh"

module spi_rx_tb;

    import spi_rx_pkg::*;

    logic         SCLK;
    logic         RST;
    logic         enable;
    logic         sdi_a;
    logic         sen_a;
    logic         sdi_b;
    logic         sen_b;
    logic         credit_return;
    rx_word_t     out_word;
    logic         out_valid;
    lane_status_t status_a;
    lane_status_t status_b;

    integer seed;
    integer credit_seed;
    integer cycle_cnt;
    integer cycle_limit;
    logic   en_model;
    logic   withhold;

    // model state per lane
    logic [31:0] exp_q [2][$];
    integer      due_q [$];
    integer      bits_left [2];
    integer      gap_left [2];
    integer      frames_left [2];
    logic        ending [2];
    logic [15:0] acc [2];
    integer      nacc [2];
    logic [11:0] frame_no [2];
    integer      produced [2];
    integer      left_cnt [2];
    integer      received;
    integer      returned;

    spi_rx_subsystem spi_rx_subsystem_i (
        .SCLK          (SCLK),
        .RST           (RST),
        .enable        (enable),
        .sdi_a         (sdi_a),
        .sen_a         (sen_a),
        .sdi_b         (sdi_b),
        .sen_b         (sen_b),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .status_a      (status_a),
        .status_b      (status_b)
    );

    always #4 SCLK = ~SCLK;

    //////////////////////////////
    // reporting
    //////////////////////////////
    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, act, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    // run limit
    always @(posedge SCLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
            stop_run("timeout: run took longer than the cycle limit");
    end

    //////////////////////////////
    // stimulus and model
    //////////////////////////////
    task automatic drive_pins(input integer l, input logic s, input logic d);
        if (l == 0) begin
            sen_a <= s;
            sdi_a <= d;
        end else begin
            sen_b <= s;
            sdi_b <= d;
        end
    endtask

    task automatic expect_word(input integer l, input logic [15:0] data);
        logic [3:0] id;
        id = 4'(l + 1);
        exp_q[l].push_back({id, frame_no[l], data});
        produced[l] = produced[l] + 1;
    endtask

    task automatic step_lane(input integer l, input integer min_len, input integer max_len);
        logic b;
        b = 1'($random(seed));
        if (bits_left[l] > 0) begin
            drive_pins(l, 1'b1, b);
            if (en_model) begin
                acc[l]  = {acc[l][14:0], b};
                nacc[l] = nacc[l] + 1;
                if (nacc[l] == 16) begin
                    expect_word(l, acc[l]);
                    acc[l]  = '0;
                    nacc[l] = 0;
                end
            end
            bits_left[l] = bits_left[l] - 1;
            if (bits_left[l] == 0)
                ending[l] = 1'b1;
        end else begin
            drive_pins(l, 1'b0, b);
            if (ending[l]) begin
                // sen fall flushes pending bits and steps the frame number
                ending[l] = 1'b0;
                if (en_model) begin
                    if (nacc[l] > 0)
                        expect_word(l, acc[l]);
                    frame_no[l] = frame_no[l] + 1'b1;
                end
                acc[l]      = '0;
                nacc[l]     = 0;
                gap_left[l] = 1 + ($unsigned($random(seed)) % 4);
            end else if (gap_left[l] > 0) begin
                gap_left[l] = gap_left[l] - 1;
            end else if (frames_left[l] > 0) begin
                frames_left[l] = frames_left[l] - 1;
                bits_left[l]   = min_len + ($unsigned($random(seed)) % (max_len - min_len + 1));
            end
        end
    endtask

    task automatic run_phase(input integer frames, input integer min_len, input integer max_len);
        for (int l = 0; l < 2; l++) begin
            frames_left[l] = frames;
            gap_left[l]    = $unsigned($random(seed)) % 4;
        end
        while (frames_left[0] > 0 || bits_left[0] > 0 || ending[0] ||
               frames_left[1] > 0 || bits_left[1] > 0 || ending[1]) begin
            @(posedge SCLK);
            step_lane(0, min_len, max_len);
            step_lane(1, min_len, max_len);
        end
    endtask

    task automatic set_enable(input logic v);
        @(posedge SCLK);
        enable   <= v;
        en_model = v;
    endtask

    // sen high while disabled, sen falls as enable rises
    task automatic zero_bit_frame();
        @(posedge SCLK);
        sen_a <= 1'b1;
        sen_b <= 1'b1;
        @(posedge SCLK);
        sen_a    <= 1'b0;
        sen_b    <= 1'b0;
        enable   <= 1'b1;
        en_model = 1'b1;
        for (int l = 0; l < 2; l++)
            frame_no[l] = frame_no[l] + 1'b1;
    endtask

    task automatic wait_drain();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || due_q.size() != 0)
            @(posedge SCLK);
        repeat (4) @(posedge SCLK);
    endtask

    task automatic check_frames();
        check("status_a.frame", 32'(status_a.frame), 32'(frame_no[0]));
        check("status_b.frame", 32'(status_b.frame), 32'(frame_no[1]));
    endtask

    //////////////////////////////
    // consumer
    //////////////////////////////
    task automatic take_word(input logic [31:0] w);
        integer l;
        if (w[31:28] == 4'd1)
            l = 0;
        else if (w[31:28] == 4'd2)
            l = 1;
        else
            stop_run("output word carries an unknown lane id");
        if (exp_q[l].size() == 0)
            stop_run("output word arrived from a lane with no word expected");
        check("out_word", w, exp_q[l].pop_front());
        left_cnt[l] = left_cnt[l] + 1;
    endtask

    always @(posedge SCLK) begin
        if (!RST) begin
            credit_return <= 1'b0;
            if (!withhold && due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
                void'(due_q.pop_front());
                credit_return <= 1'b1;
                returned = returned + 1;
            end
            if (out_valid) begin
                take_word(out_word);
                received = received + 1;
                due_q.push_back(cycle_cnt + 1 + ($unsigned($random(credit_seed)) % 4));
            end
            if (received - returned > `OUT_CREDITS)
                stop_run("more words outstanding than the consumer can buffer");
        end
    end

    //////////////////////////////
    // test sequence
    //////////////////////////////
    initial begin
        integer lost_exp;
        seed          = 30;
        credit_seed   = seed + 1;
        cycle_cnt     = 0;
        // 31 frames per lane of at most 46 cycles each
        cycle_limit   = 4 * (31 * 46) + 200;
        SCLK          = 1'b0;
        RST           = 1'b1;
        enable        = 1'b0;
        sdi_a         = 1'b0;
        sen_a         = 1'b0;
        sdi_b         = 1'b0;
        sen_b         = 1'b0;
        credit_return = 1'b0;
        en_model      = 1'b0;
        withhold      = 1'b0;
        received      = 0;
        returned      = 0;
        for (int l = 0; l < 2; l++) begin
            bits_left[l] = 0;
            gap_left[l]  = 0;
            frames_left[l] = 0;
            ending[l]    = 1'b0;
            acc[l]       = '0;
            nacc[l]      = 0;
            frame_no[l]  = '0;
            produced[l]  = 0;
            left_cnt[l]  = 0;
        end
        repeat (10) @(posedge SCLK);
        RST <= 1'b0;

        // full and partial words under steady credits
        set_enable(1'b1);
        run_phase(20, 1, 40);
        wait_drain();
        check("status_a.lost", 32'(status_a.lost), 32'd0);
        check("status_b.lost", 32'(status_b.lost), 32'd0);
        check_frames();

        // disabled lanes write nothing and hold the frame number
        set_enable(1'b0);
        run_phase(5, 1, 40);
        repeat (8) @(posedge SCLK);
        check_frames();

        // a frame of zero bits writes no word but advances the frame number
        zero_bit_frame();
        repeat (4) @(posedge SCLK);
        check_frames();

        // queues overflow while credits are withheld
        wait_drain();
        withhold = 1'b1;
        for (int l = 0; l < 2; l++) begin
            produced[l] = 0;
            left_cnt[l] = 0;
        end
        run_phase(6, 32, 40);
        repeat (10) @(posedge SCLK);
        check("words out without credit", 32'(left_cnt[0] + left_cnt[1]), `OUT_CREDITS);
        for (int l = 0; l < 2; l++) begin
            lost_exp = produced[l] - `LANE_FIFO_DEPTH - left_cnt[l];
            if (lost_exp < 0)
                lost_exp = 0;
            if (lost_exp > (1 << `LOST_BITS) - 1)
                lost_exp = (1 << `LOST_BITS) - 1;
            // the newest words were the ones dropped
            while (exp_q[l].size() > `LANE_FIFO_DEPTH)
                void'(exp_q[l].pop_back());
            if (l == 0)
                check("status_a.lost", 32'(status_a.lost), lost_exp);
            else
                check("status_b.lost", 32'(status_b.lost), lost_exp);
        end

        // queued words drain once credits return
        withhold = 1'b0;
        wait_drain();
        check_frames();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
hdl/spi_rx_pkg.sv
hdl/stream_fifo.sv
hdl/spi_rx_lane.sv
hdl/lane_merge.sv
hdl/spi_rx_subsystem.sv
tb/spi_rx_props.sv
tb/spi_rx_tb.sv

/* Makefile */
# Verilator build for the two-lane serial receiver
VERILATOR ?= verilator
TOP       ?= spi_rx_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
